/* flist.f */
verilog/cpu_pkg.sv
verilog/pipe_ctl_if.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/pipe_reg.sv
verilog/retire_unit.sv
verilog/cpu_top.sv
tb/tb_clk_gen.sv
tb/cpu_chk.sv
tb/tb_cpu.sv

/* tb/cpu_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_chk (
    input logic clk,
    input logic rst_n,
    input logic halted,
    input logic data_read,
    input logic data_write,
    input logic wwd_valid
);

    int err_cnt = 0;

    a_halt_sticky : assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else begin
        err_cnt++;
        $error("halted dropped while out of reset");
    end

    a_mem_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) !(data_read && data_write)
    ) else begin
        err_cnt++;
        $error("data_read and data_write high together");
    end

    // nothing retires once halted
    a_no_wwd_halted : assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !wwd_valid
    ) else begin
        err_cnt++;
        $error("wwd_valid pulse after halt");
    end

endmodule

bind cpu_top cpu_chk u_cpu_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .halted     (halted),
    .data_read  (data_read),
    .data_write (data_write),
    .wwd_valid  (wwd_valid)
);

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // held low for three cycles
    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

endmodule

`default_nettype wire

/* tb/tb_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int       INST_CNT_W = 16;
    localparam reg_idx_t R0 = 2'd0;
    localparam reg_idx_t R1 = 2'd1;
    localparam reg_idx_t R2 = 2'd2;
    localparam reg_idx_t R3 = 2'd3;
    localparam word_t    HLT_WORD = 16'hF01D;   // opcode 15, func 29

    logic                  clk;
    logic                  rst_n;
    word_t                 instr_addr;
    word_t                 instr_data;
    word_t                 data_addr;
    logic                  data_read;
    logic                  data_write;
    word_t                 data_wdata;
    word_t                 data_rdata;
    logic                  wwd_valid;
    word_t                 wwd_value;
    logic [INST_CNT_W-1:0] num_inst;
    logic                  halted;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       exp_dmem [256];
    word_t       exp_wwd [$];
    int          prog_len;
    logic        fill_dmem = 1'b0;
    logic [31:0] lfsr;
    string       test_name = "";
    logic        running = 1'b0;
    int          wwd_seen = 0;
    int          wwd_errs = 0;
    int          wwd_base;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          chk_errs;

    tb_clk_gen #(.PERIOD(10)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_top #(.INST_CNT_W(INST_CNT_W)) u_cpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_addr  (data_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .wwd_valid  (wwd_valid),
        .wwd_value  (wwd_value),
        .num_inst   (num_inst),
        .halted     (halted)
    );

    assign instr_data = imem[instr_addr[7:0]];
    assign data_rdata = data_read ? dmem[data_addr[7:0]] : '0;

    function automatic word_t dmem_pattern(input int a);
        return {a[7:0] ^ 8'h3c, ~a[7:0]};
    endfunction

    always @(posedge clk) begin
        if (fill_dmem) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= dmem_pattern(a);
            end
        end else if (data_write) begin
            dmem[data_addr[7:0]] <= data_wdata;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t rtype_word(input func_e fn, input reg_idx_t rs,
                                         input reg_idx_t rt, input reg_idx_t rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t itype_word(input opcode_e op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(input logic [11:0] target);
        return {OP_JMP, target};
    endfunction

    // ISA-level model stepping one instruction at a time
    function automatic void cpu_ref(output int count);
        word_t r [4];
        word_t pc;
        word_t cur;
        word_t w;
        word_t a;
        word_t b;
        word_t simm;
        word_t ea;
        logic  done;
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            exp_dmem[i] = dmem[i];
        end
        exp_wwd.delete();
        pc    = '0;
        count = 0;
        done  = 1'b0;
        while (!done && count < 1000) begin
            cur  = pc;
            w    = imem[cur[7:0]];
            a    = r[w[11:10]];
            b    = r[w[9:8]];
            simm = {{8{w[7]}}, w[7:0]};
            ea   = a + simm;
            pc   = cur + 16'd1;
            count++;
            case (w[15:12])
                OP_ADI: r[w[9:8]] = a + simm;
                OP_ORI: r[w[9:8]] = a | {8'h00, w[7:0]};
                OP_LHI: r[w[9:8]] = {w[7:0], 8'h00};
                OP_LWD: r[w[9:8]] = exp_dmem[ea[7:0]];
                OP_SWD: exp_dmem[ea[7:0]] = b;
                OP_BNE: if (a != b) pc = cur + 16'd1 + simm;
                OP_BEQ: if (a == b) pc = cur + 16'd1 + simm;
                OP_JMP: pc = {cur[15:12], w[11:0]};
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADD: r[w[7:6]] = a + b;
                        FN_SUB: r[w[7:6]] = a - b;
                        FN_AND: r[w[7:6]] = a & b;
                        FN_ORR: r[w[7:6]] = a | b;
                        FN_NOT: r[w[7:6]] = ~a;
                        FN_SHL: r[w[7:6]] = a << 1;
                        FN_SHR: r[w[7:6]] = $signed(a) >>> 1;   // sign fill
                        FN_WWD: exp_wwd.push_back(a);
                        FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endfunction

    // compare WWD pulses in order
    always @(negedge clk) begin
        if (running && rst_n && wwd_valid) begin
            if (wwd_seen - wwd_base >= exp_wwd.size()) begin
                $display("%s: WWD pulse with value %h beyond the expected list",
                         test_name, wwd_value);
                wwd_errs++;
            end else if (wwd_value !== exp_wwd[wwd_seen - wwd_base]) begin
                $display("FAIL %s wwd[%0d]: expected %h, actual %h", test_name,
                         wwd_seen - wwd_base, exp_wwd[wwd_seen - wwd_base], wwd_value);
                wwd_errs++;
            end
            wwd_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout in test %s, no halt within %0d cycles", test_name, cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic start_program();
        for (int a = 0; a < 256; a++) begin
            imem[a] = HLT_WORD;
        end
        prog_len    = 0;
        cycle_limit += 50;
        fill_dmem   = 1'b1;
        @(posedge clk);
        #1 fill_dmem = 1'b0;
    endtask

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
        cycle_limit += 8;
    endtask

    task automatic run_test(input string name);
        int exp_count;
        int errs;
        int err_base;
        int bad_words;
        test_name = name;
        cpu_ref(exp_count);
        wwd_base = wwd_seen;
        err_base = wwd_errs;
        running  = 1'b1;
        u_clk_gen.apply_reset();
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (8) @(posedge clk);  // window for stray pulses
        running = 1'b0;
        errs    = wwd_errs - err_base;
        if (wwd_seen - wwd_base != exp_wwd.size()) begin
            $display("FAIL %s wwd count: expected %0d, actual %0d", name,
                     exp_wwd.size(), wwd_seen - wwd_base);
            errs++;
        end
        if (num_inst !== exp_count[INST_CNT_W-1:0]) begin
            $display("FAIL %s num_inst: expected %0d, actual %0d", name, exp_count, num_inst);
            errs++;
        end
        if (halted !== 1'b1) begin
            $display("%s: halted did not stay high after HLT", name);
            errs++;
        end
        bad_words = 0;
        for (int a = 0; a < 256; a++) begin
            if (dmem[a] !== exp_dmem[a]) begin
                if (bad_words == 0) begin
                    $display("FAIL %s dmem[%0d]: expected %h, actual %h", name, a,
                             exp_dmem[a], dmem[a]);
                end
                bad_words++;
            end
        end
        if (bad_words != 0) begin
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("test %s ok, %0d WWD values, %0d retired", name, exp_wwd.size(), exp_count);
        end else begin
            n_fail++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    task automatic alu_program();
        start_program();
        emit(itype_word(OP_LHI, R0, R1, 8'h12));
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(itype_word(OP_ORI, R1, R1, 8'hb4));     // zero extended
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(itype_word(OP_ADI, R0, R2, 8'hfb));     // -5
        emit(rtype_word(FN_WWD, R2, R0, R0));
        emit(rtype_word(FN_ADD, R1, R2, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_SUB, R1, R2, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_AND, R1, R2, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_ORR, R1, R2, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_NOT, R1, R0, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_SHL, R2, R0, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_SHR, R2, R0, R3));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(HLT_WORD);
    endtask

    task automatic mem_program();
        start_program();
        emit(itype_word(OP_ADI, R0, R1, 8'd8));
        emit(itype_word(OP_LHI, R0, R2, 8'hab));
        emit(itype_word(OP_ORI, R2, R2, 8'hcd));
        emit(itype_word(OP_SWD, R1, R2, 8'd0));       // M[8]
        emit(itype_word(OP_ADI, R2, R3, 8'd1));
        emit(itype_word(OP_SWD, R1, R3, 8'hfe));      // M[6]
        emit(itype_word(OP_LWD, R1, R3, 8'd0));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(itype_word(OP_LWD, R1, R0, 8'hfe));
        emit(rtype_word(FN_WWD, R0, R0, R0));
        emit(itype_word(OP_LWD, R1, R2, 8'd5));       // untouched fill word
        emit(rtype_word(FN_WWD, R2, R0, R0));
        emit(HLT_WORD);
    endtask

    task automatic dependence_program();
        start_program();
        emit(itype_word(OP_ADI, R0, R1, 8'd3));
        emit(rtype_word(FN_ADD, R1, R1, R2));
        emit(rtype_word(FN_SUB, R2, R1, R3));
        emit(rtype_word(FN_SHL, R3, R0, R3));
        emit(rtype_word(FN_ORR, R3, R2, R0));
        emit(rtype_word(FN_WWD, R0, R0, R0));
        emit(itype_word(OP_ADI, R0, R1, 8'd16));
        emit(itype_word(OP_SWD, R1, R1, 8'd0));
        emit(itype_word(OP_LWD, R1, R2, 8'd0));
        emit(rtype_word(FN_ADD, R2, R2, R3));         // load-use
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(rtype_word(FN_WWD, R2, R0, R0));
        emit(rtype_word(FN_SUB, R3, R2, R0));
        emit(rtype_word(FN_WWD, R0, R0, R0));
        emit(HLT_WORD);
    endtask

    task automatic branch_program();
        start_program();
        emit(itype_word(OP_ADI, R0, R1, 8'd5));
        emit(itype_word(OP_ADI, R0, R2, 8'd5));
        emit(itype_word(OP_BEQ, R1, R2, 8'd2));       // taken to 5
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(rtype_word(FN_WWD, R2, R0, R0));
        emit(itype_word(OP_BNE, R1, R2, 8'd3));
        emit(itype_word(OP_ADI, R0, R3, 8'd7));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(itype_word(OP_BNE, R1, R3, 8'd1));       // taken to 10
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(itype_word(OP_BEQ, R1, R3, 8'd1));
        emit(jump_word(12'd14));
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(rtype_word(FN_WWD, R2, R0, R0));
        emit(itype_word(OP_ADI, R3, R3, 8'd1));
        emit(rtype_word(FN_WWD, R3, R0, R0));
        emit(itype_word(OP_ADI, R1, R1, 8'hff));      // countdown loop
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(itype_word(OP_BNE, R1, R0, 8'hfd));
        emit(HLT_WORD);
    endtask

    task automatic halt_program();
        start_program();
        emit(itype_word(OP_ADI, R0, R1, 8'd9));
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(HLT_WORD);
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(itype_word(OP_ADI, R1, R1, 8'd1));
        emit(rtype_word(FN_WWD, R1, R0, R0));
        emit(rtype_word(FN_WWD, R1, R0, R0));
    endtask

    task automatic random_program();
        logic [31:0] r;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [7:0]  imm;
        start_program();
        for (int i = 0; i < 40; i++) begin
            r   = rand_bits(18);
            rs  = r[17:16];
            rt  = r[15:14];
            rd  = r[13:12];
            imm = r[11:4];
            case (r[3:0])
                4'd0: emit(rtype_word(FN_ADD, rs, rt, rd));
                4'd1: emit(rtype_word(FN_SUB, rs, rt, rd));
                4'd2: emit(rtype_word(FN_AND, rs, rt, rd));
                4'd3: emit(rtype_word(FN_ORR, rs, rt, rd));
                4'd4: emit(rtype_word(FN_NOT, rs, rt, rd));
                4'd5: emit(rtype_word(FN_SHL, rs, rt, rd));
                4'd6: emit(rtype_word(FN_SHR, rs, rt, rd));
                4'd7: emit(itype_word(OP_ADI, rs, rt, imm));
                4'd8: emit(itype_word(OP_ORI, rs, rt, imm));
                4'd9: emit(itype_word(OP_LHI, rs, rt, imm));
                default: emit(rtype_word(FN_WWD, rs, R0, R0));
            endcase
        end
        emit(HLT_WORD);
    endtask

    initial begin
        lfsr = 32'h028a_280d;
        alu_program();
        run_test("alu_imm");
        mem_program();
        run_test("load_store");
        dependence_program();
        run_test("dependences");
        branch_program();
        run_test("control_flow");
        halt_program();
        run_test("halt");
        random_program();
        run_test("random");
        chk_errs = u_cpu_top.u_cpu_chk.err_cnt;
        $display("%0d tests passed, %0d failed, %0d assertion failures",
                 n_pass, n_fail, chk_errs);
        if (n_fail == 0 && chk_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_SHL,
        ALU_SHR,
        ALU_LHI
    } alu_op_e;

    // r-type view of an instruction word
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        func_e    func;
    } instr_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     alu_src_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     is_branch;
        logic     branch_eq;
        logic     is_jump;
        logic     is_wwd;
        logic     is_halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     is_wwd;
        logic     is_halt;
        word_t    wwd_value;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    mem_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
        logic     is_wwd;
        logic     is_halt;
        word_t    wwd_value;
    } mem_wb_t;

endpackage

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int INST_CNT_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output word_t                 instr_addr,
    input  word_t                 instr_data,
    output word_t                 data_addr,
    output logic                  data_read,
    output logic                  data_write,
    output word_t                 data_wdata,
    input  word_t                 data_rdata,
    output logic                  wwd_valid,
    output word_t                 wwd_value,
    output logic [INST_CNT_W-1:0] num_inst,
    output logic                  halted
);

    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;
    reg_idx_t rs, rt;
    logic     uses_rs, uses_rt;
    logic     bubble;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    pipe_ctl_if u_ctl ();

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctl        (u_ctl.fetch),
        .halted     (halted),
        .pc         (),
        .if_out     (if_id_d),
        .instr_addr (instr_addr),
        .instr_data (instr_data)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk (clk), .rst_n (rst_n), .hold (u_ctl.stall), .flush (u_ctl.flush),
        .d   (if_id_d), .q (if_id_q)
    );

    decode_unit u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_in   (if_id_q),
        .id_out  (id_ex_d),
        .rs      (rs),
        .rt      (rt),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    hazard_unit u_hazard (
        .ctl     (u_ctl.hazard),
        .rs      (rs),
        .rt      (rt),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt),
        .id_ex   (id_ex_q),
        .ex_mem  (ex_mem_q),
        .bubble  (bubble)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk (clk), .rst_n (rst_n), .hold (1'b0), .flush (bubble),
        .d   (id_ex_d), .q (id_ex_q)
    );

    execute_unit u_execute (
        .ctl    (u_ctl.exec),
        .id_in  (id_ex_q),
        .ex_out (ex_mem_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk (clk), .rst_n (rst_n), .hold (1'b0), .flush (1'b0),
        .d   (ex_mem_d), .q (ex_mem_q)
    );

    // data memory answers in the same cycle
    assign data_addr  = ex_mem_q.alu_result;
    assign data_wdata = ex_mem_q.store_data;
    assign data_read  = ex_mem_q.valid && ex_mem_q.mem_read;
    assign data_write = ex_mem_q.valid && ex_mem_q.mem_write;

    assign mem_wb_d.valid      = ex_mem_q.valid;
    assign mem_wb_d.alu_result = ex_mem_q.alu_result;
    assign mem_wb_d.mem_data   = data_rdata;
    assign mem_wb_d.rd         = ex_mem_q.rd;
    assign mem_wb_d.reg_write  = ex_mem_q.reg_write;
    assign mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
    assign mem_wb_d.is_wwd     = ex_mem_q.is_wwd;
    assign mem_wb_d.is_halt    = ex_mem_q.is_halt;
    assign mem_wb_d.wwd_value  = ex_mem_q.wwd_value;

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk (clk), .rst_n (rst_n), .hold (1'b0), .flush (1'b0),
        .d   (mem_wb_d), .q (mem_wb_q)
    );

    retire_unit #(.INST_CNT_W(INST_CNT_W)) u_retire (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_in     (mem_wb_q),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .wwd_valid (wwd_valid),
        .wwd_value (wwd_value),
        .num_inst  (num_inst),
        .halted    (halted)
    );

endmodule

`default_nettype wire

/* verilog/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  if_id_t   if_in,
    output id_ex_t   id_out,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output logic     uses_rs,
    output logic     uses_rt,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    instr_t     f;
    logic [7:0] imm8;
    word_t      rs_val;
    word_t      rt_val;

    assign f    = if_in.instr;
    assign imm8 = if_in.instr[7:0];
    assign rs   = f.rs;
    assign rt   = f.rt;

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (f.rs),
        .raddr2 (f.rt),
        .rdata1 (rs_val),
        .rdata2 (rt_val),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    always_comb begin
        id_out        = '0;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        id_out.valid  = if_in.valid;
        id_out.pc     = if_in.pc;
        id_out.rs_val = rs_val;
        id_out.rt_val = rt_val;
        id_out.rd     = f.rt;                       // i-type target
        id_out.alu_op = ALU_ADD;
        id_out.imm    = {{8{imm8[7]}}, imm8};

        case (f.opcode)
            OP_RTYPE: begin
                id_out.rd = f.rd;
                case (f.func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        id_out.reg_write = 1'b1;
                        uses_rs          = 1'b1;
                        uses_rt          = 1'b1;
                    end
                    FN_NOT, FN_SHL, FN_SHR: begin
                        id_out.reg_write = 1'b1;
                        uses_rs          = 1'b1;
                    end
                    FN_WWD: begin
                        id_out.is_wwd = 1'b1;
                        uses_rs       = 1'b1;
                    end
                    FN_HLT:  id_out.is_halt = 1'b1;
                    default: ;                      // unknown func acts as nop
                endcase
                case (f.func)
                    FN_SUB:  id_out.alu_op = ALU_SUB;
                    FN_AND:  id_out.alu_op = ALU_AND;
                    FN_ORR:  id_out.alu_op = ALU_OR;
                    FN_NOT:  id_out.alu_op = ALU_NOT;
                    FN_SHL:  id_out.alu_op = ALU_SHL;
                    FN_SHR:  id_out.alu_op = ALU_SHR;
                    default: id_out.alu_op = ALU_ADD;
                endcase
            end
            OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
                id_out.alu_src_imm = 1'b1;
                id_out.reg_write   = 1'b1;
                uses_rs            = (f.opcode != OP_LHI);
                if (f.opcode == OP_ORI) begin
                    id_out.alu_op = ALU_OR;
                    id_out.imm    = {8'h00, imm8};  // zero extend
                end else if (f.opcode == OP_LHI) begin
                    id_out.alu_op = ALU_LHI;
                    id_out.imm    = {imm8, 8'h00};
                end else if (f.opcode == OP_LWD) begin
                    id_out.mem_read   = 1'b1;
                    id_out.mem_to_reg = 1'b1;
                end
            end
            OP_SWD: begin
                id_out.alu_src_imm = 1'b1;
                id_out.mem_write   = 1'b1;
                uses_rs            = 1'b1;
                uses_rt            = 1'b1;          // store data
            end
            OP_BNE, OP_BEQ: begin
                id_out.is_branch = 1'b1;
                id_out.branch_eq = (f.opcode == OP_BEQ);
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;
            end
            OP_JMP: begin
                id_out.is_jump = 1'b1;
                id_out.imm     = {4'h0, if_in.instr[11:0]};
            end
            default: ;
        endcase

        // bubbles never cause a stall
        if (!if_in.valid) begin
            uses_rs = 1'b0;
            uses_rt = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
    pipe_ctl_if.exec ctl,
    input  id_ex_t   id_in,
    output ex_mem_t  ex_out
);

    word_t op_a;
    word_t op_b;
    word_t alu_y;
    logic  take_branch;

    assign op_a = id_in.rs_val;
    assign op_b = id_in.alu_src_imm ? id_in.imm : id_in.rt_val;

    always_comb begin
        case (id_in.alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_NOT: alu_y = ~op_a;
            ALU_SHL: alu_y = {op_a[14:0], 1'b0};
            ALU_SHR: alu_y = {op_a[15], op_a[15:1]};  // arithmetic
            ALU_LHI: alu_y = op_b;                    // imm already placed high
            default: alu_y = op_a + op_b;
        endcase
    end

    assign take_branch = id_in.is_branch &&
                         (id_in.branch_eq == (id_in.rs_val == id_in.rt_val));

    assign ctl.redirect = id_in.valid && (take_branch || id_in.is_jump);
    assign ctl.target   = id_in.is_jump ? {id_in.pc[15:12], id_in.imm[11:0]}
                                        : id_in.pc + 16'd1 + id_in.imm;

    assign ex_out.valid      = id_in.valid;
    assign ex_out.alu_result = alu_y;
    assign ex_out.store_data = id_in.rt_val;
    assign ex_out.rd         = id_in.rd;
    assign ex_out.reg_write  = id_in.reg_write;
    assign ex_out.mem_read   = id_in.mem_read;
    assign ex_out.mem_write  = id_in.mem_write;
    assign ex_out.mem_to_reg = id_in.mem_to_reg;
    assign ex_out.is_wwd     = id_in.is_wwd;
    assign ex_out.is_halt    = id_in.is_halt;
    assign ex_out.wwd_value  = id_in.rs_val;

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    pipe_ctl_if.fetch      ctl,
    input  logic           halted,
    output word_t          pc,
    output if_id_t         if_out,
    output word_t          instr_addr,
    input  word_t          instr_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!halted) begin
            if (ctl.redirect) begin
                pc <= ctl.target;   // redirect beats stall
            end else if (!ctl.stall) begin
                pc <= pc + 16'd1;
            end
        end
    end

    assign instr_addr = pc;

    assign if_out.valid = !halted;  // no new work once halted
    assign if_out.pc    = pc;
    assign if_out.instr = instr_data;

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    pipe_ctl_if.hazard ctl,
    input  reg_idx_t   rs,
    input  reg_idx_t   rt,
    input  logic       uses_rs,
    input  logic       uses_rt,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    output logic       bubble
);

    logic ex_wr;
    logic mem_wr;
    logic raw_ex;
    logic raw_mem;

    assign ex_wr  = id_ex.valid && id_ex.reg_write;
    assign mem_wr = ex_mem.valid && ex_mem.reg_write;

    assign raw_ex  = ex_wr && ((uses_rs && rs == id_ex.rd) || (uses_rt && rt == id_ex.rd));
    assign raw_mem = mem_wr && ((uses_rs && rs == ex_mem.rd) || (uses_rt && rt == ex_mem.rd));

    // MEM/WB is handled by register file write-through
    assign ctl.stall = (raw_ex || raw_mem) && !ctl.redirect;
    assign ctl.flush = ctl.redirect;
    assign bubble    = ctl.stall || ctl.flush;

endmodule

`default_nettype wire

/* verilog/pipe_ctl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface pipe_ctl_if import cpu_pkg::*; ();

    logic  stall;
    logic  flush;
    logic  redirect;   // taken branch or jump in EX
    word_t target;

    modport hazard (output stall, output flush, input redirect);
    modport fetch  (input stall, input redirect, input target);
    modport exec   (output redirect, output target);

endinterface

`default_nettype wire

/* verilog/pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload means valid is 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;            // flush beats hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through covers the WB/ID overlap
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/retire_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module retire_unit import cpu_pkg::*; #(
    parameter int INST_CNT_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_wb_t               wb_in,
    output logic                  we,
    output reg_idx_t              waddr,
    output word_t                 wdata,
    output logic                  wwd_valid,
    output word_t                 wwd_value,
    output logic [INST_CNT_W-1:0] num_inst,
    output logic                  halted
);

    logic retire;

    // anything reaching WB after HLT is squashed here
    assign retire = wb_in.valid && !halted;

    assign we    = retire && wb_in.reg_write;
    assign waddr = wb_in.rd;
    assign wdata = wb_in.mem_to_reg ? wb_in.mem_data : wb_in.alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wwd_valid <= 1'b0;
            num_inst  <= '0;
            halted    <= 1'b0;
        end else begin
            wwd_valid <= retire && wb_in.is_wwd;
            if (retire) begin
                num_inst <= num_inst + 1'b1;
            end
            if (retire && wb_in.is_halt) begin
                halted <= 1'b1;     // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire && wb_in.is_wwd) begin
            wwd_value <= wb_in.wwd_value;
        end
    end

endmodule

`default_nettype wire
